/* hw/issue_select.sv */
// issue_select: lowest-index priority picker giving one-hot grant and binary index
`default_nettype none

module issue_select #(
    parameter  int RS_DEPTH = 4,
    localparam int IDX_W    = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1
) (
    input  wire logic [RS_DEPTH-1:0] req,
    output logic      [RS_DEPTH-1:0] gnt,       // one-hot, zero when idle
    output logic      [IDX_W-1:0]    gnt_idx,
    output logic                     none       // no request at all
);

    assign gnt  = req & (~req + 1'b1);          // isolate lowest set bit
    assign none = ~|req;

    // walk down so the lowest request is the last to write
    always_comb begin
        gnt_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (req[i]) gnt_idx = IDX_W'(i);
        end
    end

endmodule

`default_nettype wire

/* hw/mul_if.sv */
// mul_if: issue bus from station to multiplier and product bus from multiplier to writeback
`default_nettype none

interface mul_issue_if import mul_pkg::*; ();
    logic              valid;       // one-cycle strobe per issued op
    mul_func_e         func;
    logic [XLEN-1:0]   opa;
    logic [XLEN-1:0]   opb;
    logic [PREG_W-1:0] dest_preg;
    logic [ROB_W-1:0]  rob_idx;

    modport rs   (output valid, func, opa, opb, dest_preg, rob_idx);
    modport pipe (input  valid, func, opa, opb, dest_preg, rob_idx);
endinterface

interface mul_prod_if import mul_pkg::*; ();
    logic              valid;
    mul_func_e         func;        // kept for half select in wb
    logic [2*XLEN-1:0] product;     // full 64-bit product
    logic [PREG_W-1:0] dest_preg;
    logic [ROB_W-1:0]  rob_idx;

    modport pipe (output valid, func, product, dest_preg, rob_idx);
    modport wb   (input  valid, func, product, dest_preg, rob_idx);
endinterface

`default_nettype wire

/* hw/mul_pipe.sv */
// mul_pipe: fixed-latency pipelined 33x33 multiplier covering all four multiply functions
`default_nettype none

module mul_pipe import mul_pkg::*; #(
    parameter int MUL_STAGES = 3                 // at least 1
) (
    input  wire logic clock,
    input  wire logic rst_n,
    input  wire logic flush,                     // kills ops in flight
    mul_issue_if.pipe issue,
    mul_prod_if.pipe  prod
);

    logic                     opa_signed;
    logic                     opb_signed;
    logic signed [XLEN:0]     opa_ext;           // 33 bits
    logic signed [XLEN:0]     opb_ext;
    logic signed [2*XLEN+1:0] full_prod;         // 66 bits, top two never needed

    logic [MUL_STAGES-1:0]    stg_valid;
    mul_func_e                stg_func  [MUL_STAGES];
    logic [2*XLEN-1:0]        stg_prod  [MUL_STAGES];
    logic [PREG_W-1:0]        stg_dest  [MUL_STAGES];
    logic [ROB_W-1:0]         stg_rob   [MUL_STAGES];

    //////////////////////////////
    // operand extension
    //////////////////////////////
    // MUL takes the signed path, the low word is the same either way
    assign opa_signed = (issue.func != MULHU);
    assign opb_signed = (issue.func == MUL) || (issue.func == MULH);

    assign opa_ext   = {opa_signed & issue.opa[XLEN-1], issue.opa};
    assign opb_ext   = {opb_signed & issue.opb[XLEN-1], issue.opb};
    assign full_prod = opa_ext * opb_ext;        // signed multiply

    //////////////////////////////
    // stage registers
    //////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else if (flush) begin
            stg_valid <= '0;                     // every in-flight op dies
        end else begin
            stg_valid[0] <= issue.valid;
            for (int s = 1; s < MUL_STAGES; s++) begin
                stg_valid[s] <= stg_valid[s-1];
            end
        end
    end

    // payload shifts every cycle, valid qualifies it
    always_ff @(posedge clock) begin
        stg_func[0] <= issue.func;
        stg_prod[0] <= full_prod[2*XLEN-1:0];
        stg_dest[0] <= issue.dest_preg;
        stg_rob[0]  <= issue.rob_idx;
        for (int s = 1; s < MUL_STAGES; s++) begin
            stg_func[s] <= stg_func[s-1];
            stg_prod[s] <= stg_prod[s-1];
            stg_dest[s] <= stg_dest[s-1];
            stg_rob[s]  <= stg_rob[s-1];
        end
    end

    // last stage drives the product bus
    assign prod.valid     = stg_valid[MUL_STAGES-1];
    assign prod.func      = stg_func[MUL_STAGES-1];
    assign prod.product   = stg_prod[MUL_STAGES-1];
    assign prod.dest_preg = stg_dest[MUL_STAGES-1];
    assign prod.rob_idx   = stg_rob[MUL_STAGES-1];

endmodule

`default_nettype wire

/* hw/mul_pkg.sv */
// mul_pkg: shared widths, multiply function codes and station entry layout
`default_nettype none

package mul_pkg;

    //////////////////////////////
    // data widths
    //////////////////////////////
    localparam int XLEN   = 32;   // integer register width
    localparam int PREG_W = 6;    // physical register tag
    localparam int ROB_W  = 5;    // reorder buffer index

    //////////////////////////////
    // multiply functions
    //////////////////////////////
    // MUL    low word, signedness does not matter
    // MULH   high word of signed x signed
    // MULHSU high word of signed opa x unsigned opb
    // MULHU  high word of unsigned x unsigned
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_func_e;

    //////////////////////////////
    // reservation station entry
    //////////////////////////////
    // a waiting operand keeps its tag in the low PREG_W bits of the value field
    typedef struct packed {
        logic                opa_ready;
        logic [XLEN-1:0]     opa_value;   // value, or awaited tag
        logic                opb_ready;
        logic [XLEN-1:0]     opb_value;   // value, or awaited tag
        logic [PREG_W-1:0]   dest_preg;
        logic [ROB_W-1:0]    rob_idx;
        mul_func_e           func;
    } rs_entry_t;   // 79 bits

endpackage

`default_nettype wire

/* hw/mul_rs.sv */
// mul_rs: multiply reservation station with dispatch, cdb wakeup and in-order-of-index issue
`default_nettype none

module mul_rs import mul_pkg::*; #(
    parameter int RS_DEPTH = 4
) (
    input  wire logic              clock,
    input  wire logic              rst_n,
    input  wire logic              flush,         // mispredict, empties station
    // dispatch
    input  wire logic              dispatch_valid,
    input  wire mul_func_e         dispatch_func,
    input  wire logic              opa_ready,
    input  wire logic [XLEN-1:0]   opa_value,
    input  wire logic [PREG_W-1:0] opa_tag,
    input  wire logic              opb_ready,
    input  wire logic [XLEN-1:0]   opb_value,
    input  wire logic [PREG_W-1:0] opb_tag,
    input  wire logic [PREG_W-1:0] dest_preg,
    input  wire logic [ROB_W-1:0]  rob_idx,
    // common data bus
    input  wire logic              cdb_valid,
    input  wire logic [PREG_W-1:0] cdb_preg,
    input  wire logic [XLEN-1:0]   cdb_value,
    output logic                   rs_full,
    mul_issue_if.rs                issue
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    rs_entry_t             entries [RS_DEPTH];
    rs_entry_t             new_entry;          // entry built from dispatch ports
    logic [RS_DEPTH-1:0]   free_mask;          // 1 = slot empty
    logic [RS_DEPTH-1:0]   free_onehot;        // lowest free slot
    logic [RS_DEPTH-1:0]   ready_mask;         // occupied and both operands ready
    logic [RS_DEPTH-1:0]   issue_gnt;
    logic [IDX_W-1:0]      issue_idx;
    logic                  issue_none;

    //////////////////////////////
    // slot allocation
    //////////////////////////////
    // same lowest-index picker as issue, fed with the free mask
    issue_select #(.RS_DEPTH(RS_DEPTH)) i_free_sel (
        .req     (free_mask),
        .gnt     (free_onehot),
        .gnt_idx (),                 // slot written through the one-hot
        .none    (rs_full)           // no free slot left
    );

    always_comb begin
        new_entry.opa_ready = opa_ready;
        new_entry.opa_value = opa_ready ? opa_value : {{(XLEN-PREG_W){1'b0}}, opa_tag};
        new_entry.opb_ready = opb_ready;
        new_entry.opb_value = opb_ready ? opb_value : {{(XLEN-PREG_W){1'b0}}, opb_tag};
        new_entry.dest_preg = dest_preg;
        new_entry.rob_idx   = rob_idx;
        new_entry.func      = dispatch_func;
    end

    //////////////////////////////
    // entry storage and wakeup
    //////////////////////////////
    // only occupied slots listen to the cdb, so a fresh dispatch is never woken here
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch_valid && free_onehot[i]) begin
                entries[i] <= new_entry;
            end else if (cdb_valid && !free_mask[i]) begin
                if (!entries[i].opa_ready && (entries[i].opa_value[PREG_W-1:0] == cdb_preg)) begin
                    entries[i].opa_ready <= 1'b1;
                    entries[i].opa_value <= cdb_value;   // tag replaced by value
                end
                if (!entries[i].opb_ready && (entries[i].opb_value[PREG_W-1:0] == cdb_preg)) begin
                    entries[i].opb_ready <= 1'b1;
                    entries[i].opb_value <= cdb_value;
                end
            end
        end
    end

    //////////////////////////////
    // ready detection and select
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready_mask[i] = !free_mask[i] && entries[i].opa_ready && entries[i].opb_ready;
        end
    end

    issue_select #(.RS_DEPTH(RS_DEPTH)) i_issue_sel (
        .req     (ready_mask),
        .gnt     (issue_gnt),
        .gnt_idx (issue_idx),
        .none    (issue_none)
    );

    // free mask: issued slot released, dispatched slot taken, same edge
    // the two never collide since one is occupied and the other free
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            free_mask <= '1;
        end else if (flush) begin
            free_mask <= '1;                     // drop everything waiting
        end else begin
            free_mask <= (free_mask | issue_gnt) & ~({RS_DEPTH{dispatch_valid}} & free_onehot);
        end
    end

    //////////////////////////////
    // issue register
    //////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
        end else if (flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= !issue_none;          // one strobe per grant
        end
    end

    always_ff @(posedge clock) begin
        if (!issue_none) begin
            issue.func      <= entries[issue_idx].func;
            issue.opa       <= entries[issue_idx].opa_value;
            issue.opb       <= entries[issue_idx].opb_value;
            issue.dest_preg <= entries[issue_idx].dest_preg;
            issue.rob_idx   <= entries[issue_idx].rob_idx;
        end
    end

endmodule

`default_nettype wire

/* hw/mul_unit_top.sv */
// mul_unit_top: multiply unit joining reservation station, multiplier pipe and writeback
`default_nettype none

module mul_unit_top import mul_pkg::*; #(
    parameter int RS_DEPTH   = 4,
    parameter int MUL_STAGES = 3
) (
    input  wire logic              clock,
    input  wire logic              rst_n,
    // dispatch
    input  wire logic              dispatch_valid,   // never while rs_full
    input  wire mul_func_e         dispatch_func,
    input  wire logic              opa_ready,
    input  wire logic [XLEN-1:0]   opa_value,
    input  wire logic [PREG_W-1:0] opa_tag,
    input  wire logic              opb_ready,
    input  wire logic [XLEN-1:0]   opb_value,
    input  wire logic [PREG_W-1:0] opb_tag,
    input  wire logic [PREG_W-1:0] dest_preg,
    input  wire logic [ROB_W-1:0]  rob_idx,
    output logic                   rs_full,
    // cdb
    input  wire logic              cdb_valid,
    input  wire logic [PREG_W-1:0] cdb_preg,
    input  wire logic [XLEN-1:0]   cdb_value,
    input  wire logic              flush,            // one-cycle pulse
    // result broadcast
    output logic                   result_valid,
    output logic [PREG_W-1:0]      result_preg,
    output logic [ROB_W-1:0]       result_rob,
    output logic [XLEN-1:0]        result_value
);

    mul_issue_if issue_bus ();
    mul_prod_if  prod_bus ();

    //////////////////////////////
    // station -> pipe -> wb
    //////////////////////////////
    mul_rs #(.RS_DEPTH(RS_DEPTH)) i_rs (
        .clock, .rst_n, .flush,
        .dispatch_valid, .dispatch_func,
        .opa_ready, .opa_value, .opa_tag,
        .opb_ready, .opb_value, .opb_tag,
        .dest_preg, .rob_idx,
        .cdb_valid, .cdb_preg, .cdb_value,
        .rs_full,
        .issue (issue_bus.rs)
    );

    mul_pipe #(.MUL_STAGES(MUL_STAGES)) i_pipe (
        .clock, .rst_n, .flush,
        .issue (issue_bus.pipe),
        .prod  (prod_bus.pipe)
    );

    mul_wb i_wb (
        .clock, .rst_n, .flush,
        .prod (prod_bus.wb),
        .result_valid, .result_preg, .result_rob, .result_value
    );

endmodule

`default_nettype wire

/* hw/mul_wb.sv */
// mul_wb: picks the product half for the function and registers the result broadcast
`default_nettype none

module mul_wb import mul_pkg::*; (
    input  wire logic        clock,
    input  wire logic        rst_n,
    input  wire logic        flush,
    mul_prod_if.wb           prod,
    output logic             result_valid,
    output logic [PREG_W-1:0] result_preg,
    output logic [ROB_W-1:0]  result_rob,
    output logic [XLEN-1:0]   result_value
);

    logic [XLEN-1:0] half_sel;

    // low word for MUL, high word for the three MULH variants
    assign half_sel = (prod.func == MUL) ? prod.product[XLEN-1:0]
                                         : prod.product[2*XLEN-1:XLEN];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (flush) begin
            result_valid <= 1'b0;                // squash the last product too
        end else begin
            result_valid <= prod.valid;
        end
    end

    always_ff @(posedge clock) begin
        result_preg  <= prod.dest_preg;
        result_rob   <= prod.rob_idx;
        result_value <= half_sel;
    end

endmodule

`default_nettype wire

/* mul_unit_top.f */
hw/mul_pkg.sv
hw/mul_if.sv
hw/issue_select.sv
hw/mul_rs.sv
hw/mul_pipe.sv
hw/mul_wb.sv
hw/mul_unit_top.sv
tests/mul_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the multiply unit testbench with verilator and run it
# exit status is nonzero when the run ends in $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module mul_unit_tb \
    -f mul_unit_top.f -o mul_unit_sim &&
./obj_dir/mul_unit_sim || exit 1

/* tests/mul_unit_tb.sv */
// mul_unit_tb: testbench for the multiply unit with reference model, scoreboard and watchdog
`default_nettype none

module mul_unit_tb import mul_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RS_DEPTH    = 4;
    localparam int MUL_STAGES  = 3;
    localparam int N_DIRECTED  = 16;                    // 4 functions x 4 operand pairs
    localparam int N_RAND      = 24;
    localparam int DRAIN_LIMIT = 4 * RS_DEPTH + MUL_STAGES + 8;
    localparam int TEST_CYCLES = 16 + (N_DIRECTED + N_RAND + 12) * (MUL_STAGES + 4) * 2;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;  // margin on top

    logic clock, rst_n, flush, dispatch_valid, opa_ready, opb_ready, rs_full;
    mul_func_e         dispatch_func;
    logic [XLEN-1:0]   opa_value, opb_value, cdb_value, result_value;
    logic [PREG_W-1:0] opa_tag, opb_tag, dest_preg, cdb_preg, result_preg;
    logic [ROB_W-1:0]  rob_idx, result_rob;
    logic              cdb_valid, result_valid;

    // scoreboard, one slot per rob index
    logic              exp_valid  [32];
    logic [XLEN-1:0]   exp_value  [32];
    logic [PREG_W-1:0] exp_preg   [32];
    int                exp_lat    [32];             // 0 means latency not checked
    int                disp_cycle [32];
    int                outstanding, cycle, rob_cnt, tag_cnt;
    integer            seed = 32'hf8eec98b;
    logic [PREG_W-1:0] pend_tag [$];                // tags still to broadcast
    logic [XLEN-1:0]   pend_val [$];

    mul_unit_top #(.RS_DEPTH(RS_DEPTH), .MUL_STAGES(MUL_STAGES)) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    //////////////////////////////
    // reference model and checks
    //////////////////////////////
    function automatic logic [XLEN-1:0] mul_ref(input mul_func_e func,
                                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [63:0] a_s, a_u, b_s, b_u, p;
        a_s = {{32{a[31]}}, a};                         // sign extended
        a_u = {32'b0, a};
        b_s = {{32{b[31]}}, b};
        b_u = {32'b0, b};
        case (func)
            MULH:    p = a_s * b_s;
            MULHSU:  p = a_s * b_u;
            default: p = a_u * b_u;                     // MUL, MULHU
        endcase
        return (func == MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure("value check failed");
        end
    endtask

    // compare every broadcast result against the scoreboard
    always @(negedge clock) begin
        if (rst_n && result_valid) begin
            if (!exp_valid[result_rob]) begin
                stop_with_failure($sformatf("result for unknown rob_idx %0d", result_rob));
            end else begin
                check("result_value", result_value, exp_value[result_rob]);
                check("result_preg", result_preg, exp_preg[result_rob]);
                if (exp_lat[result_rob] != 0)
                    check("latency", cycle - disp_cycle[result_rob], exp_lat[result_rob]);
                exp_valid[result_rob] = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        stop_with_failure("watchdog timeout, tests did not finish in time");
    end

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////
    // a and b are the final operand values, waiting ones arrive later on the cdb
    task automatic dispatch(input mul_func_e f, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic wait_a, input logic wait_b,
                            input logic [PREG_W-1:0] ta, input logic [PREG_W-1:0] tb, input int lat);
        logic [ROB_W-1:0] rob;
        rob = ROB_W'(rob_cnt);
        rob_cnt++;
        while (rs_full) @(negedge clock);               // dispatcher honours full
        dispatch_valid = 1'b1;
        dispatch_func  = f;
        opa_ready = !wait_a;
        opa_value = wait_a ? $random(seed) : a;         // junk when waiting
        opa_tag   = ta;
        opb_ready = !wait_b;
        opb_value = wait_b ? $random(seed) : b;
        opb_tag   = tb;
        rob_idx   = rob;
        dest_preg = {1'b1, rob};
        exp_valid[rob]  = 1'b1;
        exp_value[rob]  = mul_ref(f, a, b);
        exp_preg[rob]   = {1'b1, rob};
        exp_lat[rob]    = lat;
        disp_cycle[rob] = cycle + 1;                    // edge that takes the dispatch
        outstanding++;
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [PREG_W-1:0] tag, input logic [XLEN-1:0] val);
        cdb_valid = 1'b1;
        cdb_preg  = tag;
        cdb_value = val;
        @(negedge clock);
        cdb_valid = 1'b0;
    endtask

    // one pending tag in random order, or an idle cycle
    task automatic broadcast_pending();
        int k;
        if (pend_tag.size() == 0) begin
            @(negedge clock);
        end else begin
            k = $unsigned($random(seed)) % pend_tag.size();
            broadcast(pend_tag[k], pend_val[k]);
            pend_tag.delete(k);
            pend_val.delete(k);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (outstanding > 0 && n < DRAIN_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (outstanding > 0)
            stop_with_failure($sformatf("%0d expected results never arrived", outstanding));
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        logic [XLEN-1:0] pa [4];
        logic [XLEN-1:0] pb [4];
        logic [XLEN-1:0] a, b, r;
        logic [PREG_W-1:0] ta, tb;
        pa = '{32'h0, 32'hffffffff, 32'h80000000, 32'h80000000};
        pb = '{32'h12345678, 32'hffffffff, 32'hffffffff, 32'h7fffffff};
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_func = MUL;
        opa_ready = 1'b0;
        opa_value = '0;
        opa_tag = '0;
        opb_ready = 1'b0;
        opb_value = '0;
        opb_tag = '0;
        dest_preg = '0;
        rob_idx = '0;
        cdb_valid = 1'b0;
        cdb_preg = '0;
        cdb_value = '0;
        outstanding = 0;
        cycle = 0;
        rob_cnt = 0;
        tag_cnt = 0;
        foreach (exp_valid[i]) exp_valid[i] = 1'b0;
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        check("result_valid", result_valid, 0);
        check("rs_full", rs_full, 0);

        // 1: ready operands, every function, corner values, exact latency
        for (int f = 0; f < 4; f++) begin
            for (int p = 0; p < 4; p++) begin
                dispatch(mul_func_e'(f), pa[p], pb[p], 0, 0, 0, 0, MUL_STAGES + 2);
                wait_drain();
            end
        end

        // 2: wakeup, a foreign tag first must not release anything
        dispatch(MULH, 32'hfffffff3, 32'h00000011, 1, 0, 6'd10, 0, 0);
        dispatch(MULHSU, 32'h87654321, 32'hdeadbeef, 1, 1, 6'd11, 6'd12, 0);
        broadcast(6'd13, 32'h1);
        repeat (MUL_STAGES + 4) @(negedge clock);
        check("outstanding", outstanding, 2);
        broadcast(6'd11, 32'h87654321);
        broadcast(6'd10, 32'hfffffff3);
        broadcast(6'd12, 32'hdeadbeef);
        wait_drain();

        // 3: fill the station behind a tag that has not arrived yet
        for (int i = 0; i < RS_DEPTH; i++)
            dispatch(mul_func_e'(i), 32'hcafe0001, 32'h1000 + i, 1, 0, 6'd20, 0, 0);
        check("rs_full", rs_full, 1);
        broadcast(6'd20, 32'hcafe0001);
        @(negedge clock);                               // first entry issued
        check("rs_full", rs_full, 0);
        wait_drain();

        // 4: random stream, waiting tags woken in random order
        for (int n = 0; n < N_RAND; n++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            ta = PREG_W'(16 + tag_cnt % 48);
            tb = PREG_W'(16 + (tag_cnt + 1) % 48);
            tag_cnt += 2;
            while (rs_full) broadcast_pending();
            dispatch(mul_func_e'(r[1:0]), a, b, r[3:2] == 2'b00, r[5:4] == 2'b00, ta, tb, 0);
            // tags only become pending once their consumer sits in the station
            if (r[3:2] == 2'b00) begin
                pend_tag.push_back(ta);
                pend_val.push_back(a);
            end
            if (r[5:4] == 2'b00) begin
                pend_tag.push_back(tb);
                pend_val.push_back(b);
            end
            if (r[6]) broadcast_pending();
        end
        while (pend_tag.size() > 0) broadcast_pending();
        wait_drain();

        // 5: flush with two ops in the multiplier and a station full of waiting ops
        dispatch(MULH, 32'h5, 32'h6, 1, 0, 6'd40, 0, 0);
        dispatch(MUL, 32'h7, 32'h9, 0, 0, 0, 0, 0);
        dispatch(MULHU, 32'hffff0000, 32'h0000ffff, 0, 0, 0, 0, 0);
        dispatch(MULHSU, 32'h5, 32'h6, 0, 1, 0, 6'd41, 0);
        dispatch(MUL, 32'h3, 32'h4, 1, 0, 6'd42, 0, 0);
        dispatch(MULHU, 32'h8, 32'ha, 0, 1, 0, 6'd43, 0);
        check("rs_full", rs_full, 1);                   // reused slots, four waiting
        foreach (exp_valid[i]) exp_valid[i] = 1'b0;    // killed ops may never show up
        outstanding = 0;
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        check("rs_full", rs_full, 0);
        broadcast(6'd40, 32'h5);
        broadcast(6'd41, 32'h6);
        broadcast(6'd42, 32'h3);
        broadcast(6'd43, 32'ha);
        repeat (MUL_STAGES + 6) @(negedge clock);
        for (int i = 0; i < RS_DEPTH; i++)
            dispatch(mul_func_e'(3 - i), 32'h01020304 * (i + 1), 32'hf0f0f0f0, 0, 0, 0, 0, 0);
        wait_drain();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
